/* sources.f */
+incdir+source
source/game_pkg.sv
source/button_sync.sv
source/frame_tick_gen.sv
source/game_fsm.sv
source/char_ctrl.sv
source/game_top.sv
sim/tb_game_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the game_top testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_game_top -f sources.f

sim_out=$(./obj_dir/Vtb_game_top)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "=== PASS ==="; then
    exit 0
else
    exit 1
fi

/* sim/tb_game_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "game_defs.svh"

module tb_game_top import game_pkg::*; ();

    localparam int GROUND_Y   = `VER_PIXELS - `GROUND_MARGIN - `CHAR_HGT;
    localparam int SPAWN_X    = `HOR_PIXELS / 5;
    localparam int LEFT_LIM   = `CHAR_LNG + `MOVE_STEP;
    localparam int RIGHT_LIM  = `HOR_PIXELS - `CHAR_LNG - `MOVE_STEP;
    localparam int WAIT_LIMIT = 2 * `FRAME_DIV + 20;

    logic        clk = 1'b0;
    logic        rst;
    logic        btn_left;
    logic        btn_right;
    logic        btn_jump;
    logic        btn_start;
    logic [11:0] pos_x;
    logic [11:0] pos_y;
    logic        flip_h;
    game_state_t game_state;
    logic        frame_tick;

    // frame-level model of the character and the round
    int          m_x;
    int          m_y;
    int          m_peak;
    int          m_cnt;
    bit          m_jump;
    bit          m_flip;
    game_state_t m_state;

    logic [31:0] lcg_state = 32'd33124;
    int          pass_count = 0;
    int          error_count = 0;
    int          test_errors;
    int          frames;
    int          hold;
    int          y_kept;

    // clocks since the last frame tick
    int          tick_gap = 0;
    bit          tick_seen = 1'b0;

    game_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .btn_left   (btn_left),
        .btn_right  (btn_right),
        .btn_jump   (btn_jump),
        .btn_start  (btn_start),
        .pos_x      (pos_x),
        .pos_y      (pos_y),
        .flip_h     (flip_h),
        .game_state (game_state),
        .frame_tick (frame_tick)
    );

    always #50 clk = ~clk;

    // ==================================================
    // helpers
    // ==================================================
    function automatic int next_rand(input int range);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[30:16]) % range;
    endfunction

    task automatic check_value(input string what, input int got, input int exp);
        if (got !== exp) begin
            $display("Error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
            error_count++;
        end else begin
            pass_count++;
        end
    endtask

    // one-cycle ticks, FRAME_DIV clocks apart, from the second tick on
    always @(negedge clk) begin
        if (rst) begin
            tick_gap  = 0;
            tick_seen = 1'b0;
        end else begin
            tick_gap++;
            if (frame_tick === 1'b1) begin
                if (tick_seen) begin
                    check_value("frame tick spacing", tick_gap, `FRAME_DIV);
                end
                tick_gap  = 0;
                tick_seen = 1'b1;
            end
        end
    end

    task automatic compare_outputs();
        check_value("pos_x", int'(pos_x), m_x);
        check_value("pos_y", int'(pos_y), m_y);
        check_value("flip_h", int'(flip_h), int'(m_flip));
        check_value("game_state", int'(game_state), int'(m_state));
    endtask

    task automatic set_buttons(input bit left, input bit right, input bit jump);
        btn_left  = left;
        btn_right = right;
        btn_jump  = jump;
    endtask

    task automatic random_buttons(input bit allow_jump);
        bit left;
        bit right;
        bit jump;
        left  = (next_rand(2) == 1);
        right = (next_rand(2) == 1);
        jump  = allow_jump && (next_rand(4) == 0);
        set_buttons(left, right, jump);
    endtask

    // one frame of the motion rules, using the buttons held over the frame
    task automatic model_frame();
        bit on_gnd;
        bit jump_nxt;
        int peak_nxt;
        if (m_state == ST_PLAY) begin
            if (btn_left) begin
                m_flip = 1'b1;
            end else if (btn_right) begin
                m_flip = 1'b0;
            end
            if (btn_left && m_x > LEFT_LIM) begin
                m_x = m_x - `MOVE_STEP;
            end else if (btn_right && m_x < RIGHT_LIM) begin
                m_x = m_x + `MOVE_STEP;
            end
            // ground contact reflects y before this frame
            on_gnd   = (m_y >= GROUND_Y);
            jump_nxt = m_jump;
            peak_nxt = m_peak;
            if (btn_jump && on_gnd) begin
                jump_nxt = 1'b1;
                peak_nxt = m_y - `JUMP_HEIGHT;
            end
            if (m_jump) begin
                if (m_y > m_peak) begin
                    m_y = m_y - `JUMP_SPEED;
                end else begin
                    jump_nxt = 1'b0;
                end
            end else if (!on_gnd && m_y < GROUND_Y) begin
                m_y = m_y + `FALL_SPEED;
            end
            m_jump = jump_nxt;
            m_peak = peak_nxt;
            m_cnt++;
            if (m_cnt == `ROUND_FRAMES) begin
                m_state = ST_OVER;
            end
        end
    endtask

    task automatic wait_tick();
        int n;
        n = 0;
        @(negedge clk);
        while (frame_tick !== 1'b1 && n < WAIT_LIMIT) begin
            n++;
            @(negedge clk);
        end
        if (frame_tick !== 1'b1) begin
            $display("timeout: no frame tick seen within %0d clock cycles", WAIT_LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    endtask

    // wait for a tick, check the new frame, then return just after a rising edge
    task automatic run_frame();
        wait_tick();
        model_frame();
        repeat (2) @(negedge clk);
        compare_outputs();
        @(posedge clk);
        #1;
    endtask

    task automatic press_start();
        set_buttons(1'b0, 1'b0, 1'b0);
        btn_start = 1'b1;
        m_state   = ST_PLAY;
        m_cnt     = 0;
        m_x       = SPAWN_X;
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d (%s) finished with %0d errors", num, name,
                 error_count - test_errors);
        test_errors = error_count;
    endtask

    // ==================================================
    // test sequence
    // ==================================================
    initial begin
        rst       = 1'b1;
        btn_left  = 1'b0;
        btn_right = 1'b0;
        btn_jump  = 1'b0;
        btn_start = 1'b0;
        m_x       = SPAWN_X;
        m_y       = GROUND_Y;
        m_peak    = 0;
        m_cnt     = 0;
        m_jump    = 1'b0;
        m_flip    = 1'b0;
        m_state   = ST_IDLE;
        test_errors = 0;

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // buttons in idle must not move anything
        repeat (3) @(negedge clk);
        compare_outputs();
        @(posedge clk);
        #1;
        repeat (4) begin
            random_buttons(1'b1);
            run_frame();
        end
        report_test(1, "idle after reset");

        press_start();
        run_frame();
        btn_start = 1'b0;
        // walk into the left edge first
        set_buttons(1'b1, 1'b0, 1'b0);
        repeat (30) run_frame();
        frames = 0;
        while (frames < 40) begin
            random_buttons(1'b0);
            hold = 1 + next_rand(8);
            repeat (hold) run_frame();
            frames += hold;
        end
        report_test(2, "left and right steps");

        set_buttons(btn_left, btn_right, 1'b1);
        run_frame();
        frames = 0;
        while ((m_jump || m_y < GROUND_Y) && frames < 150) begin
            random_buttons(1'b1);
            run_frame();
            frames++;
        end
        report_test(3, "jump and fall");

        frames = 0;
        while (m_state == ST_PLAY && frames < 250) begin
            random_buttons(1'b1);
            hold = 1 + next_rand(8);
            repeat (hold) run_frame();
            frames += hold;
        end
        random_buttons(1'b1);
        repeat (5) run_frame();
        check_value("game_state after round", int'(game_state), int'(ST_OVER));
        report_test(4, "round end");

        y_kept = m_y;
        press_start();
        repeat (10) @(negedge clk);
        check_value("pos_x after restart", int'(pos_x), SPAWN_X);
        check_value("pos_y after restart", int'(pos_y), y_kept);
        check_value("game_state after restart", int'(game_state), int'(ST_PLAY));
        run_frame();
        btn_start = 1'b0;
        // walk into the right edge from the spawn point
        set_buttons(1'b0, 1'b1, 1'b0);
        repeat (130) run_frame();
        repeat (10) begin
            random_buttons(1'b1);
            run_frame();
        end
        report_test(5, "restart");

        $display("checks passed: %0d, errors: %0d", pass_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/game_top.sv */
`timescale 1ns/1ps
`default_nettype none

module game_top import game_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   btn_left,
    input  wire logic   btn_right,
    input  wire logic   btn_jump,
    input  wire logic   btn_start,
    output logic [11:0] pos_x,
    output logic [11:0] pos_y,
    output logic        flip_h,
    output game_state_t game_state,
    output logic        frame_tick
);

    // synchronized buttons
    logic        step_left;
    logic        step_right;
    logic        step_jump;
    logic        start_pulse;

    // round control and ground contact loop
    logic        game_start;
    logic        on_ground;
    logic [11:0] ground_lvl;

    // ==================================================
    // input path and frame pacing
    // ==================================================
    button_sync i_button_sync (
        .clk         (clk),
        .rst         (rst),
        .btn_left    (btn_left),
        .btn_right   (btn_right),
        .btn_jump    (btn_jump),
        .btn_start   (btn_start),
        .step_left   (step_left),
        .step_right  (step_right),
        .step_jump   (step_jump),
        .start_pulse (start_pulse)
    );

    frame_tick_gen i_frame_tick_gen (
        .clk        (clk),
        .rst        (rst),
        .frame_tick (frame_tick)
    );

    // ==================================================
    // round FSM and character
    // ==================================================
    game_fsm i_game_fsm (
        .clk         (clk),
        .rst         (rst),
        .start_pulse (start_pulse),
        .frame_tick  (frame_tick),
        .pos_y       (pos_y),
        .ground_lvl  (ground_lvl),
        .game_active (game_state),
        .game_start  (game_start),
        .on_ground   (on_ground)
    );

    char_ctrl i_char_ctrl (
        .clk         (clk),
        .rst         (rst),
        .stepleft    (step_left),
        .stepright   (step_right),
        .stepjump    (step_jump),
        .on_ground   (on_ground),
        .game_active (game_state),
        .game_start  (game_start),
        .frame_tick  (frame_tick),
        .pos_x       (pos_x),
        .pos_y       (pos_y),
        .ground_lvl  (ground_lvl),
        .flip_h      (flip_h)
    );

endmodule

`default_nettype wire

/* source/char_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "game_defs.svh"

module char_ctrl import game_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        stepleft,
    input  wire logic        stepright,
    input  wire logic        stepjump,
    input  wire logic        on_ground,
    input  wire game_state_t game_active,
    input  wire logic        game_start,
    input  wire logic        frame_tick,
    output logic [11:0]      pos_x,
    output logic [11:0]      pos_y,
    output logic [11:0]      ground_lvl,
    output logic             flip_h
);

    localparam logic [11:0] SPAWN_X   = 12'(`HOR_PIXELS / 5);
    localparam logic [11:0] GROUND_Y  = 12'(`VER_PIXELS - `GROUND_MARGIN - `CHAR_HGT);
    localparam logic [11:0] LEFT_LIM  = 12'(`CHAR_LNG + `MOVE_STEP);
    localparam logic [11:0] RIGHT_LIM = 12'(`HOR_PIXELS - `CHAR_LNG - `MOVE_STEP);
    localparam logic [11:0] JUMP_H    = 12'(`JUMP_HEIGHT);
    localparam logic [11:0] JUMP_DY   = 12'(`JUMP_SPEED);
    localparam logic [11:0] FALL_DY   = 12'(`FALL_SPEED);
    localparam logic [11:0] STEP_DX   = 12'(`MOVE_STEP);

    logic [11:0] char_x;
    logic [11:0] char_y;
    logic [11:0] jump_peak;
    logic        is_jumping;
    logic        playing;
    logic        frame_en;

    assign playing  = (game_active == ST_PLAY);
    assign frame_en = frame_tick && playing;

    // facing follows the last step, any clock during play
    always_ff @(posedge clk) begin
        if (rst) begin
            flip_h <= 1'b0;
        end else if (playing) begin
            if (stepleft) begin
                flip_h <= 1'b1;
            end else if (stepright) begin
                flip_h <= 1'b0;
            end
        end
    end

    // ==================================================
    // horizontal motion
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst || game_start) begin
            char_x <= SPAWN_X;
        end else if (frame_en) begin
            // left wins when both are held
            if (stepleft && char_x > LEFT_LIM) begin
                char_x <= char_x - STEP_DX;
            end else if (stepright && char_x < RIGHT_LIM) begin
                char_x <= char_x + STEP_DX;
            end
        end
    end

    // ==================================================
    // vertical motion
    // ==================================================
    // round start does not touch y
    always_ff @(posedge clk) begin
        if (rst) begin
            char_y     <= GROUND_Y;
            is_jumping <= 1'b0;
        end else if (frame_en) begin
            if (stepjump && on_ground) begin
                is_jumping <= 1'b1;
                jump_peak  <= char_y - JUMP_H;
            end
            if (is_jumping) begin
                if (char_y > jump_peak) begin
                    char_y <= char_y - JUMP_DY;
                end else begin
                    is_jumping <= 1'b0;
                end
            end else if (!on_ground && char_y < GROUND_Y) begin
                char_y <= char_y + FALL_DY;
            end
        end
    end

    // output stage, one clock behind the working position
    always_ff @(posedge clk) begin
        pos_x      <= char_x;
        pos_y      <= char_y;
        ground_lvl <= GROUND_Y;
    end

endmodule

`default_nettype wire

/* source/game_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "game_defs.svh"

module game_fsm import game_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        start_pulse,
    input  wire logic        frame_tick,
    input  wire logic [11:0] pos_y,
    input  wire logic [11:0] ground_lvl,
    output game_state_t      game_active,
    output logic             game_start,
    output logic             on_ground
);

    localparam int CNT_W = $clog2(`ROUND_FRAMES + 1);
    localparam logic [CNT_W-1:0] LAST_FRAME = CNT_W'(`ROUND_FRAMES - 1);

    game_state_t      state;
    game_state_t      state_nxt;
    logic [CNT_W-1:0] frame_cnt;
    logic             round_end;

    // the tick that brings the count up to ROUND_FRAMES
    assign round_end = frame_tick && (frame_cnt == LAST_FRAME);

    // ==================================================
    // round state machine
    // ==================================================
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE, ST_OVER: begin
                if (start_pulse) begin
                    state_nxt = ST_PLAY;
                end
            end
            ST_PLAY: begin
                // a start during play restarts the round
                if (start_pulse) begin
                    state_nxt = ST_PLAY;
                end else if (round_end) begin
                    state_nxt = ST_OVER;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            game_start <= 1'b0;
        end else begin
            state      <= state_nxt;
            game_start <= start_pulse;
        end
    end

    // frames played in this round
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_cnt <= '0;
        end else if (start_pulse) begin
            frame_cnt <= '0;
        end else if (state == ST_PLAY && frame_tick) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    // ==================================================
    // ground contact
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            on_ground <= 1'b0;
        end else begin
            on_ground <= (pos_y >= ground_lvl);
        end
    end

    assign game_active = state;

endmodule

`default_nettype wire

/* source/frame_tick_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "game_defs.svh"

module frame_tick_gen (
    input  wire logic clk,
    input  wire logic rst,
    output logic      frame_tick
);

    localparam int DIV_W = $clog2(`FRAME_DIV);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`FRAME_DIV - 1);

    logic [DIV_W-1:0] div_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt    <= '0;
            frame_tick <= 1'b0;
        end else begin
            // wrap back to zero after the last count
            if (div_cnt == DIV_LAST) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            frame_tick <= (div_cnt == DIV_LAST);
        end
    end

endmodule

`default_nettype wire

/* source/button_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module button_sync (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic btn_left,
    input  wire logic btn_right,
    input  wire logic btn_jump,
    input  wire logic btn_start,
    output logic      step_left,
    output logic      step_right,
    output logic      step_jump,
    output logic      start_pulse
);

    // bit order is left, right, jump, start
    logic [3:0] meta_q;
    logic [3:0] sync_q;
    logic       start_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            meta_q      <= '0;
            sync_q      <= '0;
            start_last  <= 1'b0;
            start_pulse <= 1'b0;
        end else begin
            meta_q      <= {btn_start, btn_jump, btn_right, btn_left};
            sync_q      <= meta_q;
            start_last  <= sync_q[3];
            // one clock wide, on the rising edge of start only
            start_pulse <= sync_q[3] & ~start_last;
        end
    end

    assign step_left  = sync_q[0];
    assign step_right = sync_q[1];
    assign step_jump  = sync_q[2];

endmodule

`default_nettype wire

/* source/game_pkg.sv */
`default_nettype none

package game_pkg;

    // round state, also carried on the game_active port
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_PLAY = 2'd1,
        ST_OVER = 2'd2
    } game_state_t;

endpackage

`default_nettype wire

/* source/game_defs.svh */
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// ==================================================
// playfield
// ==================================================
`define HOR_PIXELS     800
`define VER_PIXELS     600

// character box and floor band
`define CHAR_HGT       27
`define CHAR_LNG       19
`define GROUND_MARGIN  52

// ==================================================
// motion, pixels per frame
// ==================================================
`define JUMP_HEIGHT    300
`define JUMP_SPEED     7
`define FALL_SPEED     5
`define MOVE_STEP      5

// ==================================================
// pacing
// ==================================================
// clocks per frame, kept small for short runs
`define FRAME_DIV      64
// frames in one round
`define ROUND_FRAMES   200

`endif
